// File: Bender.yml
package:
  name: cache

sources:
  - files:
      - common/cache_geometry_pkg.sv
      - common/cpu_access_pkg.sv
      - design/lane_merge.sv
      - cache/cache_line_store.sv
      - cache/cache_controller.sv
      - cache/cache_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/line_memory_model.sv
      - testbench/tb_cache.sv

// File: cache/cache_controller.sv
`timescale 1ns/1ps

module cache_controller (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cpu_valid,
    input  cpu_access_pkg::cpu_req_t      cpu_req,
    output logic                          cpu_done,
    output logic                          mem_rd,
    output logic                          mem_wr,
    output cache_geometry_pkg::mem_addr_t mem_addr,
    output cache_geometry_pkg::line_t     mem_wdata,
    input  cache_geometry_pkg::line_t     mem_rdata,
    input  cache_geometry_pkg::line_t     rd_line,
    input  cache_geometry_pkg::tag_t      rd_tag,
    input  logic                          rd_valid,
    input  logic                          rd_dirty,
    output cache_geometry_pkg::index_t    lk_index,
    output logic                          wr_en,
    output cache_geometry_pkg::line_t     wr_line,
    output cache_geometry_pkg::tag_t      wr_tag,
    output logic                          wr_dirty,
    input  cache_geometry_pkg::line_t     merged_line,
    output cache_geometry_pkg::line_t     merge_base,
    output cpu_access_pkg::cpu_req_t      req_q
);
    import cache_geometry_pkg::*;
    import cpu_access_pkg::*;

    typedef enum logic [2:0] {
        idle,
        lookup,
        write_back,
        fill_wait,
        respond
    } state_e;

    state_e state;
    logic [$clog2(mem_latency_c+1)-1:0] wait_cnt; // Cycles since the mem_rd pulse

    index_t req_index;
    tag_t   req_tag;
    logic   hit;
    logic   lookup_miss;
    logic   start_wb;
    logic   start_fill;
    logic   fill_done;

    assign req_index = req_q.addr[offset_bits_c +: index_bits_c];
    assign req_tag   = req_q.addr[offset_bits_c+index_bits_c +: tag_bits_c];
    assign lk_index  = req_index;

    assign hit         = rd_valid && (rd_tag == req_tag);
    assign lookup_miss = (state == lookup) && (req_q.size != size_invalid) && !hit;
    assign start_wb    = lookup_miss && rd_valid && rd_dirty; // Evict the old line first
    assign start_fill  = (lookup_miss && !(rd_valid && rd_dirty)) || (state == write_back);
    assign fill_done   = (state == fill_wait) && (wait_cnt == mem_latency_c);

    // Fill data arrives on mem_rdata, hits work on the stored line
    assign merge_base = (state == fill_wait) ? mem_rdata : rd_line;

    assign wr_en    = fill_done
                   || ((state == lookup) && hit && req_q.write && (req_q.size != size_invalid));
    assign wr_line  = req_q.write ? merged_line : merge_base;
    assign wr_tag   = req_tag;
    assign wr_dirty = req_q.write; // Read fills come in clean
    assign cpu_done = (state == respond);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= idle;
            mem_rd   <= 1'b0;
            mem_wr   <= 1'b0;
            wait_cnt <= '0;
        end else begin
            mem_rd <= start_fill;
            mem_wr <= start_wb;
            if (start_fill) begin
                wait_cnt <= '0;
            end else if (state == fill_wait) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            case (state)
                idle:       if (cpu_valid) state <= lookup;
                lookup: begin
                    if (!lookup_miss) begin
                        state <= respond; // Hit or invalid size
                    end else if (start_wb) begin
                        state <= write_back;
                    end else begin
                        state <= fill_wait;
                    end
                end
                write_back: state <= fill_wait;
                fill_wait:  if (fill_done) state <= respond;
                respond:    state <= idle;
                default:    state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == idle) && cpu_valid) begin
            req_q <= cpu_req;
        end
        if (start_wb) begin
            mem_addr  <= {rd_tag, req_index}; // Victim address
            mem_wdata <= rd_line;
        end else if (start_fill) begin
            mem_addr <= {req_tag, req_index};
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(mem_rd && mem_wr));

    // Every access ends with exactly one done cycle
    assert property (@(posedge clk) disable iff (!rst_n) cpu_done |=> !cpu_done);

endmodule

// File: cache/cache_line_store.sv
`timescale 1ns/1ps

module cache_line_store (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cache_geometry_pkg::index_t lk_index,
    input  logic                       wr_en,
    input  cache_geometry_pkg::line_t  wr_line,
    input  cache_geometry_pkg::tag_t   wr_tag,
    input  logic                       wr_dirty,
    output cache_geometry_pkg::line_t  rd_line,
    output cache_geometry_pkg::tag_t   rd_tag,
    output logic                       rd_valid,
    output logic                       rd_dirty
);
    import cache_geometry_pkg::*;

    line_t data_q [cache_lines_c]; // Line payload
    tag_t  tag_q  [cache_lines_c];

    logic [cache_lines_c-1:0] valid_q;
    logic [cache_lines_c-1:0] dirty_q;

    // Data and tag only mean something once valid is set
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_q[lk_index] <= wr_line;
            tag_q[lk_index]  <= wr_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[lk_index] <= 1'b1;
            dirty_q[lk_index] <= wr_dirty; // Set by stores, cleared by read fills
        end
    end

    // Lookup of the latched index
    assign rd_line  = data_q[lk_index];
    assign rd_tag   = tag_q[lk_index];
    assign rd_valid = valid_q[lk_index];
    assign rd_dirty = dirty_q[lk_index];

    // Controller must stay idle while reset is held
    assert property (@(posedge clk) !rst_n |-> !wr_en);

endmodule

// File: cache/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cpu_valid,
    input  cpu_access_pkg::cpu_req_t      cpu_req,
    output cache_geometry_pkg::word_t     cpu_rdata,
    output logic                          cpu_done,
    output logic                          mem_rd,
    output logic                          mem_wr,
    output cache_geometry_pkg::mem_addr_t mem_addr,
    output cache_geometry_pkg::line_t     mem_wdata,
    input  cache_geometry_pkg::line_t     mem_rdata
);
    import cache_geometry_pkg::*;
    import cpu_access_pkg::*;

    line_t    rd_line;
    tag_t     rd_tag;
    logic     rd_valid;
    logic     rd_dirty;
    index_t   lk_index;
    logic     wr_en;
    line_t    wr_line;
    tag_t     wr_tag;
    logic     wr_dirty;
    line_t    merged_line;
    line_t    merge_base;
    cpu_req_t req_q;

    cache_controller i_cache_controller (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_valid   (cpu_valid),
        .cpu_req     (cpu_req),
        .cpu_done    (cpu_done),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .rd_line     (rd_line),
        .rd_tag      (rd_tag),
        .rd_valid    (rd_valid),
        .rd_dirty    (rd_dirty),
        .lk_index    (lk_index),
        .wr_en       (wr_en),
        .wr_line     (wr_line),
        .wr_tag      (wr_tag),
        .wr_dirty    (wr_dirty),
        .merged_line (merged_line),
        .merge_base  (merge_base),
        .req_q       (req_q)
    );

    cache_line_store i_cache_line_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .lk_index (lk_index),
        .wr_en    (wr_en),
        .wr_line  (wr_line),
        .wr_tag   (wr_tag),
        .wr_dirty (wr_dirty),
        .rd_line  (rd_line),
        .rd_tag   (rd_tag),
        .rd_valid (rd_valid),
        .rd_dirty (rd_dirty)
    );

    // Read word comes straight from the stored line during respond
    lane_merge i_lane_merge (
        .line   (merge_base),
        .offset (req_q.addr[offset_bits_c-1:0]),
        .size   (req_q.size),
        .wdata  (req_q.wdata),
        .rword  (cpu_rdata),
        .merged (merged_line)
    );

endmodule

// File: common/cache_geometry_pkg.sv
package cache_geometry_pkg;

    // Line and word sizes
    localparam int unsigned line_bits_c   = 128;
    localparam int unsigned word_bits_c   = 32;

    // CPU address split, offset in the low bits
    localparam int unsigned offset_bits_c = 4;
    localparam int unsigned index_bits_c  = 7;
    localparam int unsigned tag_bits_c    = 7;

    localparam int unsigned cache_lines_c = 128; // One line per index value

    // Cycles from the mem_rd pulse to valid read data
    localparam int unsigned mem_latency_c = 6;

    typedef logic [line_bits_c-1:0]   line_t;
    typedef logic [word_bits_c-1:0]   word_t;
    typedef logic [offset_bits_c-1:0] offset_t;
    typedef logic [index_bits_c-1:0]  index_t;
    typedef logic [tag_bits_c-1:0]    tag_t;

    // Line address as seen by memory, tag above index
    typedef logic [tag_bits_c+index_bits_c-1:0] mem_addr_t;

endpackage

// File: common/cpu_access_pkg.sv
package cpu_access_pkg;

    // Access width, encoded as on the CPU byte select lines
    typedef enum logic [1:0] {
        size_invalid = 2'b00,
        size_byte    = 2'b01,
        size_half    = 2'b10,
        size_word    = 2'b11
    } access_size_e;

    // One CPU access, held stable from strobe to done
    typedef struct packed {
        logic                      write;  // 1 for a store
        access_size_e              size;
        logic [31:0]               addr;   // Offset 3:0, index 10:4, tag 17:11
        cache_geometry_pkg::word_t wdata;
    } cpu_req_t;

endpackage

// File: design/lane_merge.sv
`timescale 1ns/1ps

module lane_merge (
    input  cache_geometry_pkg::line_t       line,
    input  cache_geometry_pkg::offset_t     offset,
    input  cpu_access_pkg::access_size_e    size,
    input  cache_geometry_pkg::word_t       wdata,
    output cache_geometry_pkg::word_t       rword,
    output cache_geometry_pkg::line_t       merged
);
    import cache_geometry_pkg::*;
    import cpu_access_pkg::*;

    logic [$clog2(line_bits_c)-1:0] lane_pos; // Bit position of the addressed lane

    always_comb begin
        lane_pos = '0;
        rword    = '0; // Upper bits stay zero for narrow reads
        merged   = line;
        case (size)
            size_byte: begin
                lane_pos                = {offset, 3'b000};
                rword[7:0]              = line[lane_pos +: 8];
                merged[lane_pos +: 8]   = wdata[7:0];
            end
            size_half: begin
                // Offset aligned down to a half word
                lane_pos                = {offset[3:1], 4'b0000};
                rword[15:0]             = line[lane_pos +: 16];
                merged[lane_pos +: 16]  = wdata[15:0];
            end
            size_word: begin
                lane_pos                = {offset[3:2], 5'b00000};
                rword                   = line[lane_pos +: 32];
                merged[lane_pos +: 32]  = wdata;
            end
            default: begin
                merged = line; // Invalid size leaves the line alone
            end
        endcase
    end

endmodule

// File: sources.f
common/cache_geometry_pkg.sv
common/cpu_access_pkg.sv
design/lane_merge.sv
cache/cache_line_store.sv
cache/cache_controller.sv
cache/cache_top.sv
testbench/tb_clock_gen.sv
testbench/line_memory_model.sv
testbench/tb_cache.sv

// File: testbench/cache_cases.txt
// Columns are write size addr wdata rdata and mem_rd count in hex
// Size 0 is invalid, 1 byte, 2 half and 3 word. Expected rdata is ignored on write rows
0 1 00001234 00000000 00000026 1
0 2 00002346 00000000 00006465 1
0 3 0000345c 00000000 6b6a6968 1
0 3 00001230 00000000 21202322 0
0 2 0000123e 00000000 00002d2c 0
0 3 00001235 00000000 25242726 0
1 1 00001239 000000a5 00000000 0
1 2 0000123a 0000c3d4 00000000 0
0 3 00001238 00000000 c3d4a52a 0
1 3 0000456c deadbeef 00000000 1
0 1 0000456d 00000000 000000be 0
0 1 00004568 00000000 0000002d 0
0 3 00002a38 00000000 11101312 1
0 3 00001238 00000000 c3d4a52a 1
0 3 fffc1238 00000000 c3d4a52a 0
1 0 00001238 ffffffff 00000000 0
0 3 00001238 00000000 c3d4a52a 0
1 0 00007890 12345678 00000000 0
0 3 00007890 00000000 ebeae9e8 1

// File: testbench/line_memory_model.sv
`timescale 1ns/1ps

module line_memory_model (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mem_rd,
    input  logic                          mem_wr,
    input  cache_geometry_pkg::mem_addr_t mem_addr,
    input  cache_geometry_pkg::line_t     mem_wdata,
    output cache_geometry_pkg::line_t     mem_rdata
);
    import cache_geometry_pkg::*;

    localparam int unsigned mem_lines_c  = 1 << (tag_bits_c + index_bits_c);
    localparam int unsigned line_bytes_c = line_bits_c / 8;

    line_t       lines [mem_lines_c];
    mem_addr_t   rd_addr;
    int unsigned rd_wait; // Edges left until read data shows

    // Start value of a byte from its two low address bytes
    function automatic logic [7:0] byte_rule(input int unsigned b);
        return b[7:0] ^ b[15:8];
    endfunction

    initial begin
        for (int a = 0; a < mem_lines_c; a++) begin
            for (int k = 0; k < line_bytes_c; k++) begin
                lines[a][8*k +: 8] = byte_rule(a * line_bytes_c + k);
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && mem_wr) begin
            lines[mem_addr] <= mem_wdata;
        end
    end

    // Read data is driven only in the cycle mem_latency_c after mem_rd
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_wait   <= 0;
            mem_rdata <= 'x;
        end else begin
            mem_rdata <= 'x;
            if (mem_rd) begin
                rd_addr <= mem_addr;
                rd_wait <= mem_latency_c - 1;
            end else if (rd_wait != 0) begin
                rd_wait <= rd_wait - 1;
                if (rd_wait == 1) begin
                    mem_rdata <= lines[rd_addr];
                end
            end
        end
    end

endmodule

// File: testbench/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;
    import cache_geometry_pkg::*;
    import cpu_access_pkg::*;

    localparam int unsigned period_ns_c    = 40;
    localparam int unsigned reset_cycles_c = 10;
    localparam int unsigned max_rows_c     = 64;
    localparam int unsigned row_words_c    = 6;  // write size addr wdata rdata reads
    localparam int unsigned row_cycles_c   = 2 * mem_latency_c + 10;
    localparam logic [31:0] empty_c        = 32'hffff_ffff; // Marks unused rows

    logic      clk;
    logic      rst_n;
    logic      cpu_valid;
    cpu_req_t  cpu_req;
    word_t     cpu_rdata;
    logic      cpu_done;
    logic      mem_rd;
    logic      mem_wr;
    mem_addr_t mem_addr;
    line_t     mem_wdata;
    line_t     mem_rdata;

    logic [31:0] case_words [max_rows_c*row_words_c];
    int unsigned row_count;
    int unsigned rd_count;   // mem_rd pulses in the current access
    logic        rows_loaded;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    line_memory_model i_line_memory_model (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    cache_top i_cache_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_rdata (cpu_rdata),
        .cpu_done  (cpu_done),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    always @(posedge clk) begin
        if (rst_n && mem_rd) begin
            rd_count = rd_count + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // One access from strobe to done, then the checks for its row
    task automatic run_access(input int unsigned row);
        int unsigned base;
        logic [31:0] exp_rdata;
        logic [31:0] exp_reads;
        base      = row * row_words_c;
        exp_rdata = case_words[base+4];
        exp_reads = case_words[base+5];
        @(posedge clk);
        #2;
        cpu_req.write = case_words[base][0];
        cpu_req.size  = access_size_e'(case_words[base+1][1:0]);
        cpu_req.addr  = case_words[base+2];
        cpu_req.wdata = case_words[base+3];
        cpu_valid     = 1'b1;
        rd_count      = 0;
        @(posedge clk);
        #2;
        cpu_valid = 1'b0; // One-cycle strobe
        do begin
            @(negedge clk);
        end while (cpu_done !== 1'b1);
        if (!cpu_req.write) begin
            check_value("cpu_rdata", cpu_rdata, exp_rdata);
        end
        check_value("mem_rd count", rd_count, exp_reads);
    endtask

    initial begin
        rows_loaded = 1'b0;
        cpu_valid   = 1'b0;
        cpu_req     = '0;
        rd_count    = 0;
        for (int i = 0; i < max_rows_c * row_words_c; i++) begin
            case_words[i] = empty_c;
        end
        $readmemh("testbench/cache_cases.txt", case_words);
        row_count = 0;
        while (row_count < max_rows_c && case_words[row_count*row_words_c] !== empty_c) begin
            row_count++;
        end
        rows_loaded = 1'b1;
        if (row_count == 0) begin
            $display("no access rows were found in testbench/cache_cases.txt");
            $display("SIMULATION FAILED");
            $fatal(1, "empty cases file");
        end else begin
            wait (rst_n === 1'b1);
            for (int r = 0; r < row_count; r++) begin
                run_access(r);
            end
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    // Watchdog sized from the number of rows
    initial begin
        longint unsigned limit_ns;
        wait (rows_loaded === 1'b1);
        limit_ns = longint'(reset_cycles_c + row_count * row_cycles_c) * period_ns_c;
        #(limit_ns);
        $display("timeout: the cache did not finish all %0d accesses in time", row_count);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int unsigned half_period_ns_c = 20; // 40 ns clock
    localparam int unsigned reset_cycles_c   = 10;

    initial begin
        clk = 1'b0;
        forever #(half_period_ns_c) clk = ~clk;
    end

    // Release just after a rising edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles_c) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule
